//--- vga_pkg.sv
// VGA display controller
// Shared constants and types

package vga_pkg;

    // Horizontal raster in pixel clocks
    localparam int h_visible = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_back    = 48;
    localparam int h_total   = h_visible + h_front + h_sync + h_back;

    // Vertical raster in lines
    localparam int v_visible = 480;
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_back    = 33;
    localparam int v_total   = v_visible + v_front + v_sync + v_back;

    localparam int h_sync_start = h_visible + h_front;
    localparam int h_sync_end   = h_sync_start + h_sync;
    localparam int v_sync_start = v_visible + v_front;
    localparam int v_sync_end   = v_sync_start + v_sync;

    // Text geometry
    localparam int text_cols   = 80;
    localparam int text_rows   = 25;
    localparam int char_height = 16;
    localparam int char_width  = 8;
    localparam int border_row  = text_rows * char_height;

    // Odd graphics lines live in the upper bank
    localparam int gfx_bytes_per_line = 40;
    localparam int gfx_odd_bank       = 4096;

    localparam int fb_depth        = 8192;
    localparam int cursor_pos_bits = 11;

    typedef logic [9:0]  pixel_coord_t;
    typedef logic [12:0] fb_addr_t;
    typedef logic [19:1] bus_addr_t;
    typedef logic [15:0] bus_data_t;
    typedef logic [1:0]  byte_sel_t;
    typedef logic [3:0]  attr_t;
    typedef logic [1:0]  gfx_colour_t;

    // Register word offsets
    localparam logic [1:0] reg_cursor_pos = 2'd0;
    localparam logic [1:0] reg_cursor_ctl = 2'd1;
    localparam logic [1:0] reg_mode       = 2'd2;

    // Graphics palettes, indexed by pixel value
    localparam attr_t [3:0] palette_0 = {4'd6, 4'd4, 4'd2, 4'd0};
    localparam attr_t [3:0] palette_1 = {4'd7, 4'd5, 4'd3, 4'd0};

endpackage

//--- vga_timing.sv
// VGA raster timing generator

`timescale 1ns/1ps

module vga_timing import vga_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    output pixel_coord_t row,
    output pixel_coord_t col,
    output logic         is_blank,
    output logic         is_border,
    output logic         hsync,
    output logic         vsync
);

    pixel_coord_t h_count;
    pixel_coord_t v_count;
    logic         h_last;
    logic         v_last;

    assign h_last = h_count == pixel_coord_t'(h_total - 1);
    assign v_last = v_count == pixel_coord_t'(v_total - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_count <= '0;
        end else if (h_last) begin
            h_count <= '0;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // Line counter advances at the end of each line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_count <= '0;
        end else if (h_last) begin
            if (v_last) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end
    end

    assign row = v_count;
    assign col = h_count;

    assign is_blank = (h_count >= pixel_coord_t'(h_visible)) ||
                      (v_count >= pixel_coord_t'(v_visible));

    // Lines below the text area are border
    assign is_border = (v_count >= pixel_coord_t'(border_row)) &&
                       (v_count <  pixel_coord_t'(v_visible));

    // Active low syncs
    assign hsync = !((h_count >= pixel_coord_t'(h_sync_start)) &&
                     (h_count <  pixel_coord_t'(h_sync_end)));
    assign vsync = !((v_count >= pixel_coord_t'(v_sync_start)) &&
                     (v_count <  pixel_coord_t'(v_sync_end)));

endmodule

//--- vga_regs.sv
// Cursor and mode registers

`timescale 1ns/1ps

module vga_regs import vga_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cs,
    input  logic                       access,
    input  logic                       wr_en,
    input  bus_addr_t                  addr,
    input  bus_data_t                  data_in,
    input  byte_sel_t                  bytesel,
    output bus_data_t                  data_out,
    output logic                       ack,
    output logic                       cursor_enabled,
    output logic [cursor_pos_bits-1:0] cursor_pos,
    output logic [2:0]                 cursor_scan_start,
    output logic [2:0]                 cursor_scan_end,
    output logic                       graphics_enabled,
    output logic                       palette_sel
);

    logic       wr;
    logic [6:0] cursor_ctl;
    logic [1:0] mode;
    bus_data_t  rd_word;
    bus_data_t  rd_q;

    assign wr = access && cs && wr_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cursor_pos <= '0;
            cursor_ctl <= '0;
            mode       <= '0;
        end else if (wr) begin
            case (addr[2:1])
                reg_cursor_pos: begin
                    if (bytesel[0]) cursor_pos[7:0]  <= data_in[7:0];
                    if (bytesel[1]) cursor_pos[10:8] <= data_in[10:8];
                end
                reg_cursor_ctl: if (bytesel[0]) cursor_ctl <= data_in[6:0];
                reg_mode:       if (bytesel[0]) mode <= data_in[1:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        case (addr[2:1])
            reg_cursor_pos: rd_word = bus_data_t'(cursor_pos);
            reg_cursor_ctl: rd_word = bus_data_t'(cursor_ctl);
            reg_mode:       rd_word = bus_data_t'(mode);
            default:        rd_word = '0;
        endcase
    end

    // Read data is sampled before any write at the same edge
    always_ff @(posedge clk) begin
        rd_q <= rd_word;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= access && cs;
        end
    end

    assign data_out = ack ? rd_q : '0;

    assign cursor_enabled    = cursor_ctl[0];
    assign cursor_scan_start = cursor_ctl[3:1];
    assign cursor_scan_end   = cursor_ctl[6:4];
    assign graphics_enabled  = mode[0];
    assign palette_sel       = mode[1];

endmodule

//--- frame_buffer_ram.sv
// Frame buffer dual-port RAM

`timescale 1ns/1ps

module frame_buffer_ram import vga_pkg::*; (
    input  logic      clk,
    input  fb_addr_t  addr_a,
    input  byte_sel_t byteena_a,
    input  bus_data_t data_a,
    input  logic      wren_a,
    output bus_data_t q_a,
    input  fb_addr_t  addr_b,
    output bus_data_t q_b
);

    bus_data_t mem [fb_depth];

    // CPU port returns the old data on a write
    always_ff @(posedge clk) begin
        q_a <= mem[addr_a];
        if (wren_a) begin
            for (int i = 0; i < 2; i++) begin
                if (byteena_a[i]) begin
                    mem[addr_a][i*8 +: 8] <= data_a[i*8 +: 8];
                end
            end
        end
    end

    // Display port is read only
    always_ff @(posedge clk) begin
        q_b <= mem[addr_b];
    end

endmodule

//--- frame_buffer.sv
// Frame buffer with raster address mapping

`timescale 1ns/1ps

module frame_buffer import vga_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cs,
    input  logic                       access,
    output logic                       ack,
    input  bus_addr_t                  addr,
    input  logic                       wr_en,
    input  bus_data_t                  data_in,
    output bus_data_t                  data_out,
    input  byte_sel_t                  bytesel,
    input  pixel_coord_t               row,
    input  pixel_coord_t               col,
    input  logic                       is_blank,
    input  logic                       is_border,
    input  logic                       cursor_enabled,
    input  logic [cursor_pos_bits-1:0] cursor_pos,
    input  logic [2:0]                 cursor_scan_start,
    input  logic [2:0]                 cursor_scan_end,
    input  logic                       graphics_enabled,
    output logic [7:0]                 glyph,
    output attr_t                      background,
    output attr_t                      foreground,
    output logic                       render_cursor,
    output gfx_colour_t                graphics_colour
);

    bus_data_t    cpu_q;
    bus_data_t    vga_q;
    logic         vga_valid;
    fb_addr_t     text_addr;
    fb_addr_t     gfx_addr;
    fb_addr_t     address;
    pixel_coord_t half_row;
    pixel_coord_t half_col;
    logic [2:0]   glyph_row;
    logic [2:0]   pix_offs;
    logic [7:0]   pix_byte;

    // Text cells are 8x16 pixels, 80 per row
    assign text_addr = fb_addr_t'(row / char_height) * fb_addr_t'(text_cols) +
                       fb_addr_t'(col / char_width);

    // Graphics pixels are doubled in both directions
    assign half_row = row >> 1;
    assign half_col = col >> 1;
    assign gfx_addr = fb_addr_t'(half_row >> 1) * fb_addr_t'(gfx_bytes_per_line) +
                      fb_addr_t'(half_col >> 3) +
                      (half_row[0] ? fb_addr_t'(gfx_odd_bank) : fb_addr_t'(0));

    assign address   = graphics_enabled ? gfx_addr : text_addr;
    assign glyph_row = row[3:1];

    frame_buffer_ram i_frame_buffer_ram (
        .clk       (clk),
        .addr_a    (addr[13:1]),
        .byteena_a (bytesel),
        .data_a    (data_in),
        .wren_a    (access && cs && wr_en),
        .q_a       (cpu_q),
        .addr_b    (address),
        .q_b       (vga_q)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack           <= 1'b0;
            vga_valid     <= 1'b0;
            render_cursor <= 1'b0;
        end else begin
            ack           <= access && cs;
            vga_valid     <= !is_blank && !is_border;
            render_cursor <= !is_blank && cursor_enabled &&
                             (address[cursor_pos_bits-1:0] == cursor_pos) &&
                             (glyph_row >= cursor_scan_start) &&
                             (glyph_row <= cursor_scan_end);
        end
    end

    // Pixel offset follows the RAM read by one cycle
    always_ff @(posedge clk) begin
        pix_offs <= half_col[2:0];
    end

    assign data_out = ack ? cpu_q : '0;

    assign {background, foreground, glyph} = vga_valid ? vga_q : '0;

    // Offsets 0-3 walk the low byte from the top, 4-7 the high byte
    assign pix_byte        = pix_offs[2] ? vga_q[15:8] : vga_q[7:0];
    assign graphics_colour = vga_valid ? pix_byte[{~pix_offs[1:0], 1'b0} +: 2] : '0;

endmodule

//--- vga_output.sv
// Pixel output stage

`timescale 1ns/1ps

module vga_output import vga_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [7:0]   glyph,
    input  attr_t        foreground,
    input  attr_t        background,
    input  logic         render_cursor,
    input  gfx_colour_t  graphics_colour,
    input  logic         graphics_enabled,
    input  logic         palette_sel,
    input  logic         hsync_raw,
    input  logic         vsync_raw,
    input  pixel_coord_t row,
    input  pixel_coord_t col,
    output logic [7:0]   pixel_glyph,
    output attr_t        pixel_fg,
    output attr_t        pixel_bg,
    output logic         pixel_cursor,
    output attr_t        pixel_colour,
    output logic         hsync,
    output logic         vsync,
    output pixel_coord_t pixel_row,
    output pixel_coord_t pixel_col
);

    attr_t        colour;
    logic         hsync_d;
    logic         vsync_d;
    pixel_coord_t row_d;
    pixel_coord_t col_d;

    always_comb begin
        if (!graphics_enabled) begin
            colour = '0;
        end else if (palette_sel) begin
            colour = palette_1[graphics_colour];
        end else begin
            colour = palette_0[graphics_colour];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_glyph  <= '0;
            pixel_fg     <= '0;
            pixel_bg     <= '0;
            pixel_cursor <= 1'b0;
            pixel_colour <= '0;
            hsync_d      <= 1'b1;
            vsync_d      <= 1'b1;
            hsync        <= 1'b1;
            vsync        <= 1'b1;
            row_d        <= '0;
            col_d        <= '0;
            pixel_row    <= '0;
            pixel_col    <= '0;
        end else begin
            pixel_glyph  <= glyph;
            pixel_fg     <= foreground;
            pixel_bg     <= background;
            pixel_cursor <= render_cursor;
            pixel_colour <= colour;
            // Two stages to match the frame buffer read plus this register
            hsync_d      <= hsync_raw;
            vsync_d      <= vsync_raw;
            hsync        <= hsync_d;
            vsync        <= vsync_d;
            row_d        <= row;
            col_d        <= col;
            pixel_row    <= row_d;
            pixel_col    <= col_d;
        end
    end

endmodule

//--- vga_top.sv
// VGA display controller top level

`timescale 1ns/1ps

module vga_top import vga_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         access,
    input  logic         wr_en,
    input  bus_addr_t    addr,
    input  bus_data_t    data_in,
    input  byte_sel_t    bytesel,
    input  logic         fb_cs,
    input  logic         reg_cs,
    output logic         ack,
    output bus_data_t    data_out,
    output logic [7:0]   pixel_glyph,
    output attr_t        pixel_fg,
    output attr_t        pixel_bg,
    output logic         pixel_cursor,
    output attr_t        pixel_colour,
    output logic         hsync,
    output logic         vsync,
    output pixel_coord_t pixel_row,
    output pixel_coord_t pixel_col
);

    pixel_coord_t               row;
    pixel_coord_t               col;
    logic                       is_blank;
    logic                       is_border;
    logic                       hsync_raw;
    logic                       vsync_raw;
    logic                       fb_ack;
    logic                       reg_ack;
    bus_data_t                  fb_data_out;
    bus_data_t                  reg_data_out;
    logic                       cursor_enabled;
    logic [cursor_pos_bits-1:0] cursor_pos;
    logic [2:0]                 cursor_scan_start;
    logic [2:0]                 cursor_scan_end;
    logic                       graphics_enabled;
    logic                       palette_sel;
    logic [7:0]                 glyph;
    attr_t                      foreground;
    attr_t                      background;
    logic                       render_cursor;
    gfx_colour_t                graphics_colour;

    // Idle slaves return zero so the buses combine with an OR
    assign ack      = fb_ack | reg_ack;
    assign data_out = fb_data_out | reg_data_out;

    vga_timing i_vga_timing (
        .clk       (clk),
        .rst_n     (rst_n),
        .row       (row),
        .col       (col),
        .is_blank  (is_blank),
        .is_border (is_border),
        .hsync     (hsync_raw),
        .vsync     (vsync_raw)
    );

    vga_regs i_vga_regs (
        .clk               (clk),
        .rst_n             (rst_n),
        .cs                (reg_cs),
        .access            (access),
        .wr_en             (wr_en),
        .addr              (addr),
        .data_in           (data_in),
        .bytesel           (bytesel),
        .data_out          (reg_data_out),
        .ack               (reg_ack),
        .cursor_enabled    (cursor_enabled),
        .cursor_pos        (cursor_pos),
        .cursor_scan_start (cursor_scan_start),
        .cursor_scan_end   (cursor_scan_end),
        .graphics_enabled  (graphics_enabled),
        .palette_sel       (palette_sel)
    );

    frame_buffer i_frame_buffer (
        .clk               (clk),
        .rst_n             (rst_n),
        .cs                (fb_cs),
        .access            (access),
        .ack               (fb_ack),
        .addr              (addr),
        .wr_en             (wr_en),
        .data_in           (data_in),
        .data_out          (fb_data_out),
        .bytesel           (bytesel),
        .row               (row),
        .col               (col),
        .is_blank          (is_blank),
        .is_border         (is_border),
        .cursor_enabled    (cursor_enabled),
        .cursor_pos        (cursor_pos),
        .cursor_scan_start (cursor_scan_start),
        .cursor_scan_end   (cursor_scan_end),
        .graphics_enabled  (graphics_enabled),
        .glyph             (glyph),
        .background        (background),
        .foreground        (foreground),
        .render_cursor     (render_cursor),
        .graphics_colour   (graphics_colour)
    );

    vga_output i_vga_output (
        .clk              (clk),
        .rst_n            (rst_n),
        .glyph            (glyph),
        .foreground       (foreground),
        .background       (background),
        .render_cursor    (render_cursor),
        .graphics_colour  (graphics_colour),
        .graphics_enabled (graphics_enabled),
        .palette_sel      (palette_sel),
        .hsync_raw        (hsync_raw),
        .vsync_raw        (vsync_raw),
        .row              (row),
        .col              (col),
        .pixel_glyph      (pixel_glyph),
        .pixel_fg         (pixel_fg),
        .pixel_bg         (pixel_bg),
        .pixel_cursor     (pixel_cursor),
        .pixel_colour     (pixel_colour),
        .hsync            (hsync),
        .vsync            (vsync),
        .pixel_row        (pixel_row),
        .pixel_col        (pixel_col)
    );

endmodule

//--- tb_vga_top.sv
// Testbench for the VGA display controller

`timescale 1ns/1ps

module tb_vga_top import vga_pkg::*; ();

    localparam int clk_period    = 100;
    localparam int reset_cycles  = 8;
    localparam int settle_cycles = 4;
    localparam int ack_limit     = 4;
    localparam int frame_cycles  = h_total * v_total;
    // Fill, one text frame and one and a half graphics frames fit in three frames
    localparam int watchdog_cycles = 3 * frame_cycles;
    localparam logic [31:0] lcg_seed = 32'h760b_530e;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         access;
    logic         wr_en;
    bus_addr_t    addr;
    bus_data_t    data_in;
    byte_sel_t    bytesel;
    logic         fb_cs;
    logic         reg_cs;
    logic         ack;
    bus_data_t    data_out;
    logic [7:0]   pixel_glyph;
    attr_t        pixel_fg;
    attr_t        pixel_bg;
    logic         pixel_cursor;
    attr_t        pixel_colour;
    logic         hsync;
    logic         vsync;
    pixel_coord_t pixel_row;
    pixel_coord_t pixel_col;

    // Reference state for the frame buffer and the registers
    bus_data_t    shadow [fb_depth];
    bus_data_t    reg_shadow [3];
    logic [31:0]  lcg_state;
    int unsigned  cyc = 0;
    logic         exp_ready = 1'b0;
    logic         pix_check = 1'b0;
    logic         pix_known;
    logic         exp_hsync;
    logic         exp_vsync;
    pixel_coord_t exp_row;
    pixel_coord_t exp_col;
    logic [7:0]   exp_glyph;
    attr_t        exp_fg;
    attr_t        exp_bg;
    logic         exp_cursor;
    attr_t        exp_colour;

    vga_top i_vga_top (.*);

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bus_data_t merge_bytes(input bus_data_t old, input bus_data_t d,
                                              input byte_sel_t be);
        bus_data_t mask;
        mask = {{8{be[1]}}, {8{be[0]}}};
        return (old & ~mask) | (d & mask);
    endfunction

    function automatic bus_data_t reg_mask(input logic [1:0] off);
        case (off)
            reg_cursor_pos: return 16'h07ff;
            reg_cursor_ctl: return 16'h007f;
            default:        return 16'h0003;
        endcase
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "Run aborted");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        abort_run($sformatf("FAILED %s: got %0h, expected %0h", name, got, exp));
    endtask

    // One strobe cycle, then wait for ack and take data_out at that edge
    task automatic bus_access(input logic to_regs, input logic write, input bus_addr_t a,
                              input bus_data_t d, input byte_sel_t be, output bus_data_t q);
        int waited;
        access  <= 1'b1;
        fb_cs   <= !to_regs;
        reg_cs  <= to_regs;
        wr_en   <= write;
        addr    <= a;
        data_in <= d;
        bytesel <= be;
        @(posedge clk);
        access <= 1'b0;
        fb_cs  <= 1'b0;
        reg_cs <= 1'b0;
        wr_en  <= 1'b0;
        waited = 0;
        @(posedge clk);
        while (!ack) begin
            waited++;
            if (waited > ack_limit) begin
                abort_run("Bus access was never acknowledged");
            end
            @(posedge clk);
        end
        q = data_out;
    endtask

    task automatic write_fb(input fb_addr_t a, input bus_data_t d, input byte_sel_t be);
        bus_data_t q;
        bus_access(1'b0, 1'b1, bus_addr_t'(a), d, be, q);
        assert (q == shadow[a]) else report_mismatch("data_out", q, shadow[a]);
        shadow[a] = merge_bytes(shadow[a], d, be);
    endtask

    task automatic read_fb(input fb_addr_t a);
        bus_data_t q;
        bus_access(1'b0, 1'b0, bus_addr_t'(a), '0, 2'b00, q);
        assert (q == shadow[a]) else report_mismatch("data_out", q, shadow[a]);
    endtask

    task automatic write_reg(input logic [1:0] off, input bus_data_t d, input byte_sel_t be);
        bus_data_t q;
        bus_access(1'b1, 1'b1, bus_addr_t'(off), d, be, q);
        assert (q == reg_shadow[off]) else report_mismatch("data_out", q, reg_shadow[off]);
        reg_shadow[off] = merge_bytes(reg_shadow[off], d, be) & reg_mask(off);
    endtask

    task automatic read_reg(input logic [1:0] off);
        bus_data_t q;
        bus_access(1'b1, 1'b0, bus_addr_t'(off), '0, 2'b00, q);
        assert (q == reg_shadow[off]) else report_mismatch("data_out", q, reg_shadow[off]);
    endtask

    task automatic fill_frame_buffer();
        bus_data_t q;
        for (int i = 0; i < fb_depth; i++) begin
            lcg_state = lcg_next(lcg_state);
            shadow[i] = lcg_state[31:16];
            bus_access(1'b0, 1'b1, bus_addr_t'(i), shadow[i], 2'b11, q);
        end
    endtask

    task automatic check_fb_merge();
        fb_addr_t a;
        for (int n = 0; n < 3; n++) begin
            lcg_state = lcg_next(lcg_state);
            a = lcg_state[28:16];
            for (int be = 0; be < 4; be++) begin
                lcg_state = lcg_next(lcg_state);
                write_fb(a, lcg_state[31:16], byte_sel_t'(be));
                read_fb(a);
            end
        end
    endtask

    task automatic check_reg_merge();
        for (int r = 0; r < 3; r++) begin
            for (int be = 0; be < 4; be++) begin
                lcg_state = lcg_next(lcg_state);
                write_reg(2'(r), lcg_state[31:16], byte_sel_t'(be));
                read_reg(2'(r));
            end
            write_reg(2'(r), '0, 2'b11);
        end
    endtask

    // Pixel checks pause while the display configuration changes
    task automatic set_display(input bus_data_t mode, input bus_data_t cur_pos,
                               input bus_data_t cur_ctl);
        pix_check = 1'b0;
        write_reg(reg_cursor_pos, cur_pos, 2'b11);
        write_reg(reg_cursor_ctl, cur_ctl, 2'b11);
        write_reg(reg_mode, mode, 2'b11);
        repeat (settle_cycles) @(posedge clk);
        pix_check = 1'b1;
    endtask

    // Cycles since reset release
    always @(posedge clk) begin
        if (!rst_n) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    // Reference model of the outputs, which lag the raster by two cycles
    always @(negedge clk) begin
        int unsigned p;
        int unsigned h;
        int unsigned v;
        int unsigned a;
        int unsigned off;
        bus_data_t   w;
        logic [7:0]  pix_byte;
        logic [1:0]  px;
        exp_ready  = 1'b1;
        exp_hsync  = 1'b1;
        exp_vsync  = 1'b1;
        exp_row    = '0;
        exp_col    = '0;
        exp_glyph  = '0;
        exp_fg     = '0;
        exp_bg     = '0;
        exp_cursor = 1'b0;
        exp_colour = '0;
        pix_known  = 1'b1;
        if (cyc >= 2) begin
            p = cyc - 2;
            h = p % h_total;
            v = (p / h_total) % v_total;
            exp_row   = pixel_coord_t'(v);
            exp_col   = pixel_coord_t'(h);
            exp_hsync = !(h >= h_sync_start && h < h_sync_end);
            exp_vsync = !(v >= v_sync_start && v < v_sync_end);
            off = (h / 2) % 8;
            if (reg_shadow[reg_mode][0]) begin
                a = (v / 4) * gfx_bytes_per_line + h / 16 + ((v / 2) % 2) * gfx_odd_bank;
            end else begin
                a = (v / char_height) * text_cols + h / char_width;
            end
            exp_cursor = h < h_visible && v < v_visible && reg_shadow[reg_cursor_ctl][0] &&
                         (a % (2 ** cursor_pos_bits)) == reg_shadow[reg_cursor_pos] &&
                         (v / 2) % 8 >= reg_shadow[reg_cursor_ctl][3:1] &&
                         (v / 2) % 8 <= reg_shadow[reg_cursor_ctl][6:4];
            if (h < h_visible && v < border_row) begin
                w = shadow[a];
                exp_glyph = w[7:0];
                exp_fg    = w[11:8];
                exp_bg    = w[15:12];
                pix_byte  = (off >= 4) ? w[15:8] : w[7:0];
                px        = pix_byte[(7 - 2 * (off % 4)) -: 2];
                // Palette 0 gives 0,2,4,6 and palette 1 gives 0,3,5,7
                if (reg_shadow[reg_mode][0] && px != 2'd0) begin
                    exp_colour = attr_t'(2 * px + reg_shadow[reg_mode][1]);
                end
            end
            pix_known = pix_check;
        end
    end

    assert property (@(posedge clk) exp_ready |-> hsync == exp_hsync)
        else report_mismatch("hsync", $sampled(hsync), exp_hsync);
    assert property (@(posedge clk) exp_ready |-> vsync == exp_vsync)
        else report_mismatch("vsync", $sampled(vsync), exp_vsync);
    assert property (@(posedge clk) exp_ready |-> pixel_row == exp_row)
        else report_mismatch("pixel_row", $sampled(pixel_row), exp_row);
    assert property (@(posedge clk) exp_ready |-> pixel_col == exp_col)
        else report_mismatch("pixel_col", $sampled(pixel_col), exp_col);
    assert property (@(posedge clk) exp_ready |-> ack == $past(access && (fb_cs || reg_cs)))
        else report_mismatch("ack", $sampled(ack), !$sampled(ack));
    assert property (@(posedge clk) exp_ready && !ack |-> data_out == '0)
        else report_mismatch("data_out", $sampled(data_out), 0);
    assert property (@(posedge clk) exp_ready && pix_known |-> pixel_glyph == exp_glyph)
        else report_mismatch("pixel_glyph", $sampled(pixel_glyph), exp_glyph);
    assert property (@(posedge clk) exp_ready && pix_known |-> pixel_fg == exp_fg)
        else report_mismatch("pixel_fg", $sampled(pixel_fg), exp_fg);
    assert property (@(posedge clk) exp_ready && pix_known |-> pixel_bg == exp_bg)
        else report_mismatch("pixel_bg", $sampled(pixel_bg), exp_bg);
    assert property (@(posedge clk) exp_ready && pix_known |-> pixel_cursor == exp_cursor)
        else report_mismatch("pixel_cursor", $sampled(pixel_cursor), exp_cursor);
    assert property (@(posedge clk) exp_ready && pix_known |-> pixel_colour == exp_colour)
        else report_mismatch("pixel_colour", $sampled(pixel_colour), exp_colour);

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        abort_run("Watchdog expired before the tests completed");
    end

    initial begin
        rst_n     = 1'b0;
        access    = 1'b0;
        wr_en     = 1'b0;
        addr      = '0;
        data_in   = '0;
        bytesel   = '0;
        fb_cs     = 1'b0;
        reg_cs    = 1'b0;
        lcg_state = lcg_seed;
        for (int i = 0; i < 3; i++) begin
            reg_shadow[i] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        fill_frame_buffer();
        check_fb_merge();
        check_reg_merge();

        // Text mode with the cursor on row 12, column 37, scan lines 2 to 5
        set_display(16'h0000, bus_data_t'(12 * text_cols + 37), {9'd0, 3'd5, 3'd2, 1'b1});
        repeat (frame_cycles) @(posedge clk);

        // Graphics mode with palette 0 and then palette 1
        set_display(16'h0001, '0, '0);
        repeat (frame_cycles) @(posedge clk);
        set_display(16'h0003, '0, '0);
        repeat (frame_cycles / 2) @(posedge clk);
        pix_check = 1'b0;

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- sources.f
vga_pkg.sv
vga_timing.sv
vga_regs.sv
frame_buffer_ram.sv
frame_buffer.sv
vga_output.sv
vga_top.sv
tb_vga_top.sv

//--- Bender.yml
package:
  name: vga_display

sources:
  - vga_pkg.sv
  - vga_timing.sv
  - vga_regs.sv
  - frame_buffer_ram.sv
  - frame_buffer.sv
  - vga_output.sv
  - vga_top.sv
  - target: test
    files:
      - tb_vga_top.sv
